//--- include/cdc_fifo_params.svh
// width and threshold defaults for the dual-clock fifo, included by the package and rtl
`ifndef CDC_FIFO_PARAMS_SVH
`define CDC_FIFO_PARAMS_SVH

// bits per data word
`define CDC_FIFO_DATA_W 32

// address bits, depth is 2**ADDR_W
`define CDC_FIFO_ADDR_W 4

// almost_full rises once occupancy reaches depth minus this
// keep it below depth or almost_full is set out of reset
`define CDC_FIFO_AF_MARGIN 4

// derived depth, handy for the testbench model
`define CDC_FIFO_DEPTH (1 << `CDC_FIFO_ADDR_W)

`endif

//--- src/cdc_fifo_pkg.sv
// shared types of the dual-clock fifo, imported by the rtl modules that name them
`include "cdc_fifo_params.svh"

package cdc_fifo_pkg;

	// one payload word
	typedef logic [`CDC_FIFO_DATA_W-1:0] fifo_data_t;

	// storage address / pointer
	typedef logic [`CDC_FIFO_ADDR_W-1:0] fifo_addr_t;

	// occupancy or event count
	// one extra bit so a full fifo is representable
	typedef logic [`CDC_FIFO_ADDR_W:0] fifo_count_t;

	// write request as seen by ctrl and storage
	typedef struct packed {
		// one-cycle write strobe
		logic       en;
		// word to store
		fifo_data_t data;
	} fifo_wr_t;

endpackage

//--- src/event_sync.sv
// carries single-cycle events across clock domains as a gray count, one pulse out per event
module event_sync (
	input  logic clk_src,
	input  logic clk_dst,
	input  logic rst_n,
	input  logic clr_src,
	input  logic clr_dst,
	input  logic evt_in,
	output logic evt_out
);
	import cdc_fifo_pkg::*;

	// source side count, binary and gray copy
	fifo_count_t src_bin;
	fifo_count_t src_next;
	fifo_count_t src_gray;
	// two-flop synchronizer on the gray count
	fifo_count_t sync_q1;
	fifo_count_t sync_q2;
	// destination view of the source count
	fifo_count_t sync_bin;
	// events already replayed
	fifo_count_t dst_cnt;

	// prefix xor from the msb down
	function automatic fifo_count_t gray_to_bin(input fifo_count_t g);
		fifo_count_t b;
		b[$bits(fifo_count_t)-1] = g[$bits(fifo_count_t)-1];
		for (int i = $bits(fifo_count_t) - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	assign src_next = src_bin + 1'b1;

	always_ff @(posedge clk_src or negedge rst_n) begin
		if (!rst_n) begin
			src_bin  <= '0;
			src_gray <= '0;
		end else if (clr_src) begin
			src_bin  <= '0;
			src_gray <= '0;
		end else if (evt_in) begin
			src_bin  <= src_next;
			// only one bit of the gray register moves per event
			src_gray <= src_next ^ (src_next >> 1);
		end
	end

	always_ff @(posedge clk_dst or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			dst_cnt <= '0;
		end else if (clr_dst) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			dst_cnt <= '0;
		end else begin
			sync_q1 <= src_gray;
			sync_q2 <= sync_q1;
			// catch up one event per destination cycle
			if (evt_out) begin
				dst_cnt <= dst_cnt + 1'b1;
			end
		end
	end

	assign sync_bin = gray_to_bin(sync_q2);

	// pending events exist while the counts differ
	assign evt_out = (sync_bin != dst_cnt);

endmodule

//--- src/fifo_ram.sv
// distributed storage of the fifo, written on clk_a and read asynchronously by the clk_b side
`include "cdc_fifo_params.svh"

module fifo_ram (
	input  logic                    clk_a,
	input  cdc_fifo_pkg::fifo_wr_t   wr_req,
	input  cdc_fifo_pkg::fifo_addr_t wr_ptr,
	input  cdc_fifo_pkg::fifo_addr_t rd_ptr,
	output cdc_fifo_pkg::fifo_data_t read_data
);
	import cdc_fifo_pkg::*;

	localparam int DEPTH = 1 << `CDC_FIFO_ADDR_W;

	// word array, no reset on payload
	fifo_data_t mem [DEPTH];

	// write port in the writer domain
	always_ff @(posedge clk_a) begin
		if (wr_req.en) begin
			mem[wr_ptr] <= wr_req.data;
		end
	end

	// unregistered read at the head pointer
	// the head word is settled well before empty can fall
	assign read_data = mem[rd_ptr];

endmodule

//--- src/fifo_ctrl.sv
// pointers, occupancy counters and status flags for both domains of the dual-clock fifo
`include "cdc_fifo_params.svh"

module fifo_ctrl (
	input  logic                    clk_a,
	input  logic                    clk_b,
	input  logic                    rst_n,
	input  logic                    clr_a,
	input  logic                    clr_b,
	input  cdc_fifo_pkg::fifo_wr_t   wr_req,
	input  logic                    read,
	input  logic                    wr_evt_b,
	input  logic                    rd_evt_a,
	output cdc_fifo_pkg::fifo_addr_t wr_ptr,
	output cdc_fifo_pkg::fifo_addr_t rd_ptr,
	output logic                    empty,
	output logic                    full,
	output logic                    almost_full
);
	import cdc_fifo_pkg::*;

	// almost-full counter starts at the margin
	// so its msb sets at depth minus margin
	localparam fifo_count_t AF_INIT = fifo_count_t'(`CDC_FIFO_AF_MARGIN);

	// write side occupancy, lags reads
	fifo_count_t wr_cnt;
	// same count offset by the margin
	fifo_count_t af_cnt;
	// read side occupancy, lags writes
	fifo_count_t rd_cnt;

	logic wr_up;
	logic wr_dn;
	logic rd_up;
	logic rd_dn;

	// write and returned read in one cycle cancel out
	assign wr_up = wr_req.en & ~rd_evt_a;
	assign wr_dn = ~wr_req.en & rd_evt_a;

	// arrived write and local read likewise
	assign rd_up = wr_evt_b & ~read;
	assign rd_dn = ~wr_evt_b & read;

	// clk_a domain counters
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			wr_cnt <= '0;
			af_cnt <= AF_INIT;
		end else if (clr_a) begin
			wr_cnt <= '0;
			af_cnt <= AF_INIT;
		end else if (wr_up) begin
			wr_cnt <= wr_cnt + 1'b1;
			af_cnt <= af_cnt + 1'b1;
		end else if (wr_dn) begin
			wr_cnt <= wr_cnt - 1'b1;
			af_cnt <= af_cnt - 1'b1;
		end
	end

	// write pointer moves with the storage write
	always_ff @(posedge clk_a or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (clr_a) begin
			wr_ptr <= '0;
		end else if (wr_req.en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// clk_b domain counter
	always_ff @(posedge clk_b or negedge rst_n) begin
		if (!rst_n) begin
			rd_cnt <= '0;
		end else if (clr_b) begin
			rd_cnt <= '0;
		end else if (rd_up) begin
			rd_cnt <= rd_cnt + 1'b1;
		end else if (rd_dn) begin
			rd_cnt <= rd_cnt - 1'b1;
		end
	end

	// read pointer, head word follows combinationally
	always_ff @(posedge clk_b or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (clr_b) begin
			rd_ptr <= '0;
		end else if (read) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// msb of the count is set only at full depth
	assign full        = wr_cnt[`CDC_FIFO_ADDR_W];
	// offset count overflows past depth
	assign almost_full = af_cnt[`CDC_FIFO_ADDR_W];
	assign empty       = (rd_cnt == '0);

endmodule

//--- src/cdc_fifo_top.sv
// dual-clock fifo top level, writer on clk_a and reader on clk_b, instantiated by the testbench
module cdc_fifo_top (
	input  logic                    clk_a,
	input  logic                    clk_b,
	input  logic                    rst_n,
	input  logic                    clr_a,
	input  logic                    clr_b,
	input  logic                    write,
	input  cdc_fifo_pkg::fifo_data_t write_data,
	input  logic                    read,
	output cdc_fifo_pkg::fifo_data_t read_data,
	output logic                    empty,
	output logic                    almost_full,
	output logic                    full
);
	import cdc_fifo_pkg::*;

	fifo_wr_t   wr_req;
	fifo_addr_t wr_ptr;
	fifo_addr_t rd_ptr;
	// write seen in clk_b
	logic       wr_evt_b;
	// read seen in clk_a
	logic       rd_evt_a;

	assign wr_req = '{en: write, data: write_data};

	fifo_ctrl ctrl0 (
		.clk_a       (clk_a),
		.clk_b       (clk_b),
		.rst_n       (rst_n),
		.clr_a       (clr_a),
		.clr_b       (clr_b),
		.wr_req      (wr_req),
		.read        (read),
		.wr_evt_b    (wr_evt_b),
		.rd_evt_a    (rd_evt_a),
		.wr_ptr      (wr_ptr),
		.rd_ptr      (rd_ptr),
		.empty       (empty),
		.full        (full),
		.almost_full (almost_full)
	);

	// writes toward the reader
	event_sync wr_xing (
		.clk_src (clk_a),
		.clk_dst (clk_b),
		.rst_n   (rst_n),
		.clr_src (clr_a),
		.clr_dst (clr_b),
		.evt_in  (wr_req.en),
		.evt_out (wr_evt_b)
	);

	// reads back toward the writer
	event_sync rd_xing (
		.clk_src (clk_b),
		.clk_dst (clk_a),
		.rst_n   (rst_n),
		.clr_src (clr_b),
		.clr_dst (clr_a),
		.evt_in  (read),
		.evt_out (rd_evt_a)
	);

	fifo_ram ram0 (
		.clk_a     (clk_a),
		.wr_req    (wr_req),
		.wr_ptr    (wr_ptr),
		.rd_ptr    (rd_ptr),
		.read_data (read_data)
	);

endmodule

//--- verif/cdc_fifo_assertions.sv
// protocol and flag checks on the dual-clock fifo, bound into every cdc_fifo_top instance
module cdc_fifo_assertions (
	input logic clk_a,
	input logic clk_b,
	input logic rst_n,
	input logic clr_a,
	input logic clr_b,
	input logic write,
	input logic read,
	input logic empty,
	input logic full,
	input logic almost_full
);
	timeunit 1ns;
	timeprecision 1ps;

	// writer must hold off while full
	no_write_when_full: assert property (@(posedge clk_a) disable iff (!rst_n)
		write |-> !full)
		else $error("write issued while full");

	// reader must hold off while empty
	no_read_when_empty: assert property (@(posedge clk_b) disable iff (!rst_n)
		read |-> !empty)
		else $error("read issued while empty");

	// full is the top of the almost_full range
	full_has_af: assert property (@(posedge clk_a) disable iff (!rst_n)
		full |-> almost_full)
		else $error("full without almost_full");

	// flags return to idle after a clear
	clear_empties_b: assert property (@(posedge clk_b) disable iff (!rst_n)
		clr_b |=> empty)
		else $error("empty low after clear");
	clear_idles_a: assert property (@(posedge clk_a) disable iff (!rst_n)
		clr_a |=> (!full && !almost_full))
		else $error("full or almost_full high after clear");

endmodule

bind cdc_fifo_top cdc_fifo_assertions asrt0 (
	.clk_a       (clk_a),
	.clk_b       (clk_b),
	.rst_n       (rst_n),
	.clr_a       (clr_a),
	.clr_b       (clr_b),
	.write       (write),
	.read        (read),
	.empty       (empty),
	.full        (full),
	.almost_full (almost_full)
);

//--- verif/cdc_fifo_tb.sv
// testbench of the dual-clock fifo, runs a row table then a random stream against a queue model
`include "cdc_fifo_params.svh"

module cdc_fifo_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cdc_fifo_pkg::*;

	localparam int SEL_EMPTY = 0;
	localparam int SEL_FULL  = 1;
	localparam int SEL_AF    = 2;
	localparam int TIMEOUT   = 200;
	localparam int AF_LEVEL  = `CDC_FIFO_DEPTH - `CDC_FIFO_AF_MARGIN;
	localparam int N_ROWS    = 7;
	localparam int N_STREAM  = 200;

	// writes, reads, clear, then flags expected once settled
	typedef struct packed {
		int   n_wr;
		int   n_rd;
		logic clr;
		logic exp_empty;
		logic exp_full;
		logic exp_af;
	} row_t;

	row_t rows [N_ROWS] = '{
		'{0, 0, 1'b0, 1'b1, 1'b0, 1'b0},
		'{8, 8, 1'b0, 1'b1, 1'b0, 1'b0},
		'{16, 0, 1'b0, 1'b0, 1'b1, 1'b1},
		'{0, 1, 1'b0, 1'b0, 1'b0, 1'b1},
		'{0, 5, 1'b0, 1'b0, 1'b0, 1'b0},
		'{3, 1, 1'b1, 1'b1, 1'b0, 1'b0},
		'{6, 6, 1'b0, 1'b1, 1'b0, 1'b0}
	};

	logic       clk_a;
	logic       clk_b;
	logic       rst_n;
	logic       clr_a;
	logic       clr_b;
	logic       write;
	logic       read;
	fifo_data_t write_data;
	fifo_data_t read_data;
	logic       empty;
	logic       almost_full;
	logic       full;

	// reference model of stored words
	fifo_data_t model_q [$];
	int         seed = 32'h8dbe_64e0;

	cdc_fifo_top dut0 (.*);

	initial begin
		clk_a = 1'b0;
		forever #2 clk_a = ~clk_a;
	end

	initial begin
		clk_b = 1'b0;
		forever #3 clk_b = ~clk_b;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at %0t", $time);
	endtask

	task automatic check_data(input string name, input fifo_data_t exp, input fifo_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
				$time, name, exp, act));
		end
	endtask

	// sample on the falling edge of the flag's own clock until it matches
	task automatic wait_flag(input int sel, input logic exp);
		int   n;
		logic v;
		string name;
		n = 0;
		name = (sel == SEL_EMPTY) ? "empty" : (sel == SEL_FULL) ? "full" : "almost_full";
		forever begin
			if (sel == SEL_EMPTY) @(negedge clk_b);
			else @(negedge clk_a);
			v = (sel == SEL_EMPTY) ? empty : (sel == SEL_FULL) ? full : almost_full;
			if (v === exp) break;
			n++;
			if (n > TIMEOUT) begin
				abort_run($sformatf("timeout: %s never became %b", name, exp));
			end
		end
	endtask

	// flags lag only on the way down
	// so only a flag that should be low is waited for
	task automatic settle_flags();
		if (model_q.size() != 0) begin
			wait_flag(SEL_EMPTY, 1'b0);
		end
		if (model_q.size() != `CDC_FIFO_DEPTH) begin
			wait_flag(SEL_FULL, 1'b0);
		end
		if (model_q.size() < AF_LEVEL) begin
			wait_flag(SEL_AF, 1'b0);
		end
	endtask

	task automatic write_word(input bit af_check);
		wait_flag(SEL_FULL, 1'b0);
		write      = 1'b1;
		write_data = $random(seed);
		model_q.push_back(write_data);
		@(negedge clk_a);
		write = 1'b0;
		if (af_check) begin
			wait_flag(SEL_AF, model_q.size() >= AF_LEVEL);
		end
	endtask

	task automatic read_word();
		wait_flag(SEL_EMPTY, 1'b0);
		if (model_q.size() == 0) begin
			abort_run("reader saw data that was never written");
		end
		check_data("read_data", model_q.pop_front(), read_data);
		read = 1'b1;
		@(negedge clk_b);
		read = 1'b0;
	endtask

	task automatic apply_clear();
		settle_flags();
		// let the crossing pipelines drain first
		repeat (8) @(negedge clk_b);
		clr_a = 1'b1;
		clr_b = 1'b1;
		@(negedge clk_b);
		clr_a = 1'b0;
		clr_b = 1'b0;
		model_q.delete();
	endtask

	initial begin
		rst_n      = 1'b0;
		clr_a      = 1'b0;
		clr_b      = 1'b0;
		write      = 1'b0;
		read       = 1'b0;
		write_data = '0;
		repeat (16) @(posedge clk_a);
		@(negedge clk_a);
		rst_n = 1'b1;

		for (int r = 0; r < N_ROWS; r++) begin
			for (int i = 0; i < rows[r].n_wr; i++) write_word(1'b1);
			for (int i = 0; i < rows[r].n_rd; i++) read_word();
			if (rows[r].clr) apply_clear();
			settle_flags();
			check_flag("empty", rows[r].exp_empty, empty);
			check_flag("full", rows[r].exp_full, full);
			check_flag("almost_full", rows[r].exp_af, almost_full);
		end

		// random interleaving in both domains
		fork
			for (int i = 0; i < N_STREAM; i++) begin
				repeat ($random(seed) & 3) @(negedge clk_a);
				write_word(1'b0);
			end
			for (int i = 0; i < N_STREAM; i++) begin
				repeat ($random(seed) & 3) @(negedge clk_b);
				read_word();
			end
		join
		settle_flags();
		check_flag("empty", 1'b1, empty);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
src/cdc_fifo_pkg.sv
src/event_sync.sv
src/fifo_ram.sv
src/fifo_ctrl.sv
src/cdc_fifo_top.sv
verif/cdc_fifo_assertions.sv
verif/cdc_fifo_tb.sv

//--- Makefile
# Verilator build and run of the dual-clock FIFO testbench

VERILATOR ?= verilator
TOP       ?= cdc_fifo_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= verilog.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
